// File: bench/bus_trace.txt
# op kind addr wdata waits di rdata m1 mreq iorq rd wr rfsh rfsh_a (waits and counts decimal)
# op 0 writes register addr with wdata, op 1 runs a request, op 2 adds a req while busy
1 1 1234 00 0 5a 5a 0 1 0 1 0 0 0000
1 1 8001 00 2 c3 c3 0 3 0 3 0 0 0000
1 2 4000 a5 0 00 c3 0 1 0 0 1 0 0000
1 2 4001 3c 3 00 c3 0 1 0 0 1 0 0000
0 0 0 01 0 00 00 0 0 0 0 0 0 0000
1 2 4002 96 0 00 c3 0 1 0 0 1 0 0000
1 2 4003 69 2 00 c3 0 3 0 0 3 0 0000
1 3 0010 00 1 7e 7e 0 0 2 2 0 0 0000
1 4 0011 81 0 00 7e 0 0 1 0 1 0 0000
0 0 0 03 0 00 00 0 0 0 0 0 0 0000
1 3 0012 00 0 e7 e7 0 0 2 2 0 0 0000
1 3 0013 00 2 18 18 0 0 4 4 0 0 0000
1 4 0014 42 1 00 18 0 0 3 0 3 0 0000
1 1 1235 00 0 99 99 0 1 0 1 0 0 0000
0 0 0 02 0 00 00 0 0 0 0 0 0 0000
1 4 0015 24 1 00 99 0 0 1 0 1 0 0000
1 0 0100 00 0 3e 3e 1 1 0 1 0 0 0000
0 0 1 25 0 00 00 0 0 0 0 0 0 0000
0 0 0 04 0 00 00 0 0 0 0 0 0 0000
0 0 3 ff 0 00 00 0 0 0 0 0 0 0000
1 0 0101 00 0 ed ed 1 2 0 1 0 1 0025
1 0 0102 00 2 cb cb 3 4 0 3 0 1 0026
1 5 0000 00 1 ff ff 2 0 2 0 0 0 0000
2 1 2000 00 1 11 11 0 2 0 2 0 0 0000
2 0 0103 00 0 76 76 1 2 0 1 0 1 0027

// File: flist.f
hw/z80_bus_pkg.sv
hw/bus_phase_if.sv
hw/bus_cfg_regs.sv
hw/tstate_sequencer.sv
hw/bus_strobe_gen.sv
hw/z80_bus_top.sv
bench/z80_bus_asserts.sv
bench/z80_bus_tb.sv

// File: Bender.yml
package:
  name: z80_bus

sources:
  - hw/z80_bus_pkg.sv
  - hw/bus_phase_if.sv
  - hw/bus_cfg_regs.sv
  - hw/tstate_sequencer.sv
  - hw/bus_strobe_gen.sv
  - hw/z80_bus_top.sv
  - target: test
    files:
      - bench/z80_bus_asserts.sv
      - bench/z80_bus_tb.sv

// File: bench/z80_bus_tb.sv
`timescale 1ns/10ps
`default_nettype none

module z80_bus_tb;
  import z80_bus_pkg::*;

  localparam int IDLE_TIMEOUT = 20;  // Cycles allowed for busy to drop before a request
  localparam int REQ_TIMEOUT  = 60;  // Cycles allowed from T1 to the cycle after done

  logic                  clk;
  logic                  reset_n;
  logic                  req;
  bus_kind_e             req_kind;
  logic [ADDR_W-1:0]     req_addr;
  logic [DATA_W-1:0]     req_wdata;
  logic                  wait_n;
  logic [DATA_W-1:0]     di;
  logic                  cfg_we;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [DATA_W-1:0]     cfg_wdata;
  logic                  busy;
  logic                  done;
  logic [DATA_W-1:0]     rdata;
  logic [ADDR_W-1:0]     a;
  logic [DATA_W-1:0]     dout;
  logic                  m1_n;
  logic                  mreq_n;
  logic                  iorq_n;
  logic                  rd_n;
  logic                  wr_n;
  logic                  rfsh_n;

  // Fields of the current trace line
  int f_op;      // 0 config write, 1 request, 2 request with a req while busy
  int f_kind;
  int f_addr;    // Request address, or register address for a config write
  int f_wdata;
  int f_waits;   // Cycles of wait_n low that the sequencer looks at
  int f_di;
  int f_rdata;
  int f_m1;      // Expected low cycles per strobe
  int f_mreq;
  int f_iorq;
  int f_rd;
  int f_wr;
  int f_rfsh;
  int f_rfsh_a;  // Expected address while rfsh_n is low

  int error_count;
  int check_count;
  int req_index;
  bit timed_out;
  bit file_error;
  bit cfg_io_wait;  // Mirror of the io_wait bit last written

  z80_bus_top z80_bus_top_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (req),
    .req_kind  (req_kind),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .wait_n    (wait_n),
    .di        (di),
    .a         (a),
    .dout      (dout),
    .m1_n      (m1_n),
    .mreq_n    (mreq_n),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .rfsh_n    (rfsh_n)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Compares one observed value with the trace or the stimulus
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("[FAIL] request %0d %s: expected %0h, actual %0h",
               req_index, name, expected, actual);
    end
  endtask

  // One register write that the DUT sees on the next clock
  task automatic write_cfg();
    cfg_we    = 1'b1;
    cfg_addr  = f_addr[CFG_ADDR_W-1:0];
    cfg_wdata = f_wdata[DATA_W-1:0];
    if (f_addr == CFG_CTRL)
      cfg_io_wait = f_wdata[1];  // Forced Tw moves where wait_n starts to count
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // Issues one request and counts strobe lows from T1 to the cycle after done
  task automatic run_request();
    int cyc;
    int wait_start;
    int n_m1;
    int n_mreq;
    int n_iorq;
    int n_rd;
    int n_wr;
    int n_rfsh;
    int n_done;
    bit seen_done;
    bit finished;

    n_m1      = 0;
    n_mreq    = 0;
    n_iorq    = 0;
    n_rd      = 0;
    n_wr      = 0;
    n_rfsh    = 0;
    n_done    = 0;
    seen_done = 1'b0;
    finished  = 1'b0;
    // A forced I/O wait takes T2 in cycle 2 so wait_n counts from cycle 3
    wait_start = ((f_kind == 3 || f_kind == 4) && cfg_io_wait) ? 3 : 2;
    cyc = 0;
    while (busy && cyc < IDLE_TIMEOUT)
    begin
      @(negedge clk);
      cyc++;
    end
    if (busy)
    begin
      $display("Timeout: the bus stayed busy before request %0d", req_index);
      timed_out = 1'b1;
    end
    else
    begin
      req       = 1'b1;
      req_kind  = bus_kind_e'(f_kind[2:0]);
      req_addr  = f_addr[ADDR_W-1:0];
      req_wdata = f_wdata[DATA_W-1:0];
      di        = f_di[DATA_W-1:0];
      @(negedge clk);
      cyc = 1;  // T1
      check_value("busy in T1", 1, busy);
      while (!finished && cyc < REQ_TIMEOUT)
      begin
        req    = (f_op == 2) && (cyc == 2);  // Second pulse lands in T2 and must be lost
        wait_n = !((cyc >= wait_start) && (cyc < wait_start + f_waits));
        n_m1   += !m1_n;
        n_mreq += !mreq_n;
        n_iorq += !iorq_n;
        n_rd   += !rd_n;
        n_wr   += !wr_n;
        n_rfsh += !rfsh_n;
        n_done += done;
        if (done)
          check_value("rdata at done", f_rdata, rdata);  // Read data is in by done
        if (!rfsh_n)
          check_value("refresh address", f_rfsh_a, a);
        else if (!m1_n || !mreq_n || !iorq_n || !rd_n || !wr_n)
          check_value("address", f_addr, a);
        if (!wr_n)
          check_value("dout", f_wdata, dout);
        if (seen_done)
        begin
          finished = 1'b1;  // The last strobes show one cycle after done
          check_value("busy after done", 0, busy);
        end
        else
        begin
          seen_done = done;
          @(negedge clk);
          cyc++;
        end
      end
      req    = 1'b0;
      wait_n = 1'b1;
      if (!finished)
      begin
        $display("Timeout: request %0d gave no done within %0d cycles", req_index, REQ_TIMEOUT);
        timed_out = 1'b1;
      end
      else
      begin
        check_value("m1_n low cycles", f_m1, n_m1);
        check_value("mreq_n low cycles", f_mreq, n_mreq);
        check_value("iorq_n low cycles", f_iorq, n_iorq);
        check_value("rd_n low cycles", f_rd, n_rd);
        check_value("wr_n low cycles", f_wr, n_wr);
        check_value("rfsh_n low cycles", f_rfsh, n_rfsh);
        check_value("done pulses", 1, n_done);
      end
    end
  endtask

  initial
  begin
    int                 fd;
    int                 n_fields;
    int                 bound_fails;
    logic [8*256-1:0]   line_buf;

    reset_n     = 1'b0;
    req         = 1'b0;
    req_kind    = KIND_FETCH;
    req_addr    = '0;
    req_wdata   = '0;
    wait_n      = 1'b1;
    di          = '0;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    error_count = 0;
    check_count = 0;
    req_index   = 0;
    timed_out   = 1'b0;
    file_error  = 1'b0;
    cfg_io_wait = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Idle bus after reset
    check_value("m1_n after reset", 1, m1_n);
    check_value("mreq_n after reset", 1, mreq_n);
    check_value("iorq_n after reset", 1, iorq_n);
    check_value("rd_n after reset", 1, rd_n);
    check_value("wr_n after reset", 1, wr_n);
    check_value("rfsh_n after reset", 1, rfsh_n);
    check_value("busy after reset", 0, busy);
    check_value("done after reset", 0, done);
    check_value("rdata after reset", 0, rdata);

    fd = $fopen("bench/bus_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file bench/bus_trace.txt");
      file_error = 1'b1;
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        line_buf = '0;
        if ($fgets(line_buf, fd) != 0)
        begin
          n_fields = $sscanf(line_buf, "%h %h %h %h %d %h %h %d %d %d %d %d %d %h",
                             f_op, f_kind, f_addr, f_wdata, f_waits, f_di, f_rdata,
                             f_m1, f_mreq, f_iorq, f_rd, f_wr, f_rfsh, f_rfsh_a);
          if (n_fields == 14)  // Comment and blank lines match nothing
          begin
            if (f_op == 0)
              write_cfg();
            else
            begin
              req_index++;
              run_request();
            end
          end
        end
      end
      $fclose(fd);
      if (req_index == 0)
      begin
        $display("The trace file held no bus requests");
        file_error = 1'b1;
      end
    end

    // Strobe legality failures from the bound checker
    bound_fails = z80_bus_top_inst.bus_strobe_gen_inst.z80_bus_asserts_inst.assert_fails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d, requests: %0d",
             check_count, error_count, bound_fails, timed_out, req_index);
    if (error_count == 0 && bound_fails == 0 && !timed_out && !file_error)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/z80_bus_asserts.sv
`timescale 1ns/10ps
`default_nettype none

// Strobe legality on the external bus as driven by the strobe generator
module z80_bus_asserts (
  input logic clk,
  input logic reset_n,
  input logic m1_n,
  input logic mreq_n,
  input logic iorq_n,
  input logic rd_n,
  input logic wr_n,
  input logic rfsh_n
);

  int assert_fails;  // Number of assertion failures so far

  // A machine cycle reads or writes, never both at once
  rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset_n) !(!rd_n && !wr_n))
    else
    begin
      assert_fails++;
      $error("rd_n and wr_n are low together");
    end

  // Memory and I/O space are never selected together
  mreq_iorq_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(!mreq_n && !iorq_n))
    else
    begin
      assert_fails++;
      $error("mreq_n and iorq_n are low together");
    end

  // Refresh runs on the memory side with M1 already released
  rfsh_with_mreq: assert property (@(posedge clk) disable iff (!reset_n)
    !rfsh_n |-> (!mreq_n && m1_n))
    else
    begin
      assert_fails++;
      $error("rfsh_n low without mreq_n low and m1_n high");
    end

  // M1 only comes with an opcode read or an interrupt acknowledge
  m1_with_rd_or_iorq: assert property (@(posedge clk) disable iff (!reset_n)
    !m1_n |-> (!rd_n || !iorq_n))
    else
    begin
      assert_fails++;
      $error("m1_n low without rd_n or iorq_n low");
    end

  // A write always targets memory or an I/O port
  wr_with_space: assert property (@(posedge clk) disable iff (!reset_n)
    !wr_n |-> (!mreq_n || !iorq_n))
    else
    begin
      assert_fails++;
      $error("wr_n low without mreq_n or iorq_n low");
    end

endmodule

bind bus_strobe_gen z80_bus_asserts z80_bus_asserts_inst (
  .clk     (clk),
  .reset_n (reset_n),
  .m1_n    (m1_n),
  .mreq_n  (mreq_n),
  .iorq_n  (iorq_n),
  .rd_n    (rd_n),
  .wr_n    (wr_n),
  .rfsh_n  (rfsh_n)
);

`default_nettype wire

// File: hw/z80_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module z80_bus_top (
  input  logic                               clk,
  input  logic                               reset_n,

  // Request port from the core
  input  logic                               req,
  input  z80_bus_pkg::bus_kind_e             req_kind,
  input  logic [z80_bus_pkg::ADDR_W-1:0]     req_addr,
  input  logic [z80_bus_pkg::DATA_W-1:0]     req_wdata,
  output logic                               busy,
  output logic                               done,
  output logic [z80_bus_pkg::DATA_W-1:0]     rdata,

  // Configuration register port
  input  logic                               cfg_we,
  input  logic [z80_bus_pkg::CFG_ADDR_W-1:0] cfg_addr,
  input  logic [z80_bus_pkg::DATA_W-1:0]     cfg_wdata,

  // External bus
  input  logic                               wait_n,
  input  logic [z80_bus_pkg::DATA_W-1:0]     di,
  output logic [z80_bus_pkg::ADDR_W-1:0]     a,
  output logic [z80_bus_pkg::DATA_W-1:0]     dout,
  output logic                               m1_n,
  output logic                               mreq_n,
  output logic                               iorq_n,
  output logic                               rd_n,
  output logic                               wr_n,
  output logic                               rfsh_n
);
  import z80_bus_pkg::*;

  cfg_t cfg;  // Settings shared by sequencer and strobe generator

  bus_phase_if phase_if ();  // Current cycle from sequencer to strobe generator

  bus_cfg_regs bus_cfg_regs_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  tstate_sequencer tstate_sequencer_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (req),
    .req_kind  (req_kind),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .wait_n    (wait_n),
    .cfg       (cfg),
    .busy      (busy),
    .done      (done),
    .phase     (phase_if.seq)
  );

  bus_strobe_gen bus_strobe_gen_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .di      (di),
    .cfg     (cfg),
    .phase   (phase_if.strobe),
    .m1_n    (m1_n),
    .mreq_n  (mreq_n),
    .iorq_n  (iorq_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .rfsh_n  (rfsh_n),
    .a       (a),
    .dout    (dout),
    .rdata   (rdata)
  );

endmodule

`default_nettype wire

// File: hw/bus_strobe_gen.sv
`timescale 1ns/10ps
`default_nettype none

module bus_strobe_gen (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic [z80_bus_pkg::DATA_W-1:0]   di,        // Data bus in
  input  z80_bus_pkg::cfg_t                cfg,
  bus_phase_if.strobe                      phase,
  output logic                             m1_n,
  output logic                             mreq_n,
  output logic                             iorq_n,
  output logic                             rd_n,
  output logic                             wr_n,
  output logic                             rfsh_n,
  output logic [z80_bus_pkg::ADDR_W-1:0]   a,         // Address bus
  output logic [z80_bus_pkg::DATA_W-1:0]   dout,      // Data bus out
  output logic [z80_bus_pkg::DATA_W-1:0]   rdata      // Captured read data
);
  import z80_bus_pkg::*;

  logic                 early_win;   // T1 and every cycle that leads into a Tw
  logic                 wr_win;      // Cycles that lower wr_n
  logic                 refresh_go;  // T3 of a fetch that refreshes
  logic [REFRESH_W-1:0] rfsh_cnt;
  logic [REFRESH_W-1:0] seed_q;      // Last seen seed, to spot a new one

  // One cycle late, so the low time is 1 + W cycles
  assign early_win  = (phase.tstate == TS_T1) || phase.waiting;

  // Late writes drop wr_n only in the cycle after the wait phase ends
  assign wr_win     = cfg.t2_write ? early_win : phase.sample;
  assign refresh_go = (phase.tstate == TS_T3) && (phase.kind == KIND_FETCH) && cfg.refresh_en;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      m1_n   <= 1'b1;
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      rfsh_n <= 1'b1;
    end
    else
    begin
      // Every strobe is released unless the decode below pulls it
      m1_n   <= 1'b1;
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      rfsh_n <= 1'b1;

      case (phase.kind)
        KIND_FETCH:
        begin
          if (early_win)
          begin
            m1_n   <= 1'b0;  // M1 marks the opcode read
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          if (refresh_go)
          begin
            rfsh_n <= 1'b0;  // Refresh shows up in T4 with mreq_n alone
            mreq_n <= 1'b0;
          end
        end
        KIND_MEM_READ:
        begin
          if (early_win)
          begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
        end
        KIND_IO_READ:
        begin
          if (early_win)
          begin
            iorq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
        end
        KIND_MEM_WRITE:
        begin
          if (wr_win)
          begin
            mreq_n <= 1'b0;  // Address strobe follows the write window
            wr_n   <= 1'b0;
          end
        end
        KIND_IO_WRITE:
        begin
          if (wr_win)
          begin
            iorq_n <= 1'b0;
            wr_n   <= 1'b0;
          end
        end
        KIND_INT_ACK:
        begin
          if (early_win)
          begin
            m1_n   <= 1'b0;  // M1 with iorq_n and no rd_n flags the acknowledge
            iorq_n <= 1'b0;
          end
        end
        default:
        begin
          rd_n <= 1'b1;
        end
      endcase
    end
  end

  // A new seed reloads the counter, otherwise it counts refreshes
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      rfsh_cnt <= '0;
      seed_q   <= '0;
      rdata    <= '0;
    end
    else
    begin
      seed_q <= cfg.refresh_seed;
      if (cfg.refresh_seed != seed_q)
        rfsh_cnt <= cfg.refresh_seed;
      else if (refresh_go)
        rfsh_cnt <= rfsh_cnt + 1'b1;  // Wraps at 7 bits like the R register
      if (phase.sample && is_read_kind(phase.kind))
        rdata <= di;  // Held until the next read samples
    end
  end

  // Address and data out are registered alongside the strobes
  always_ff @(posedge clk)
  begin
    a    <= refresh_go ? {{(ADDR_W-REFRESH_W){1'b0}}, rfsh_cnt} : phase.addr;
    dout <= phase.wdata;
  end

endmodule

`default_nettype wire

// File: hw/tstate_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module tstate_sequencer (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             req,        // One-cycle request pulse
  input  z80_bus_pkg::bus_kind_e           req_kind,
  input  logic [z80_bus_pkg::ADDR_W-1:0]   req_addr,
  input  logic [z80_bus_pkg::DATA_W-1:0]   req_wdata,
  input  logic                             wait_n,     // Low stretches the cycle
  input  z80_bus_pkg::cfg_t                cfg,
  output logic                             busy,
  output logic                             done,       // High in the last T-state
  bus_phase_if.seq                         phase
);
  import z80_bus_pkg::*;

  tstate_e           tstate_q;
  tstate_e           tstate_d;
  bus_kind_e         kind_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic              accept;       // Request taken this cycle
  logic              in_wait;      // In T2 or Tw
  logic              force_wait;   // I/O cycle owed one automatic Tw
  logic              stay_wait;    // Next state is Tw
  logic              do_t4;        // Fetch continues into refresh T4

  // Requests are only seen while the bus is free, a req during a cycle is lost
  assign accept     = (tstate_q == TS_IDLE) && req;
  assign in_wait    = (tstate_q == TS_T2) || (tstate_q == TS_TW);

  // Forced wait applies only leaving T2, wait_n is not looked at there
  assign force_wait = is_io_kind(kind_q) && cfg.io_wait;
  assign stay_wait  = ((tstate_q == TS_T2) && force_wait) || !wait_n;
  assign do_t4      = (kind_q == KIND_FETCH) && cfg.refresh_en;

  always_comb
  begin
    tstate_d = tstate_q;
    case (tstate_q)
      TS_IDLE: if (req) tstate_d = TS_T1;
      TS_T1:   tstate_d = TS_T2;
      TS_T2,
      TS_TW:   tstate_d = stay_wait ? TS_TW : TS_T3;  // Each low wait_n adds a Tw
      TS_T3:   tstate_d = do_t4 ? TS_T4 : TS_IDLE;
      TS_T4:   tstate_d = TS_IDLE;
      default: tstate_d = TS_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      tstate_q <= TS_IDLE;
      kind_q   <= KIND_FETCH;
    end
    else
    begin
      tstate_q <= tstate_d;
      if (accept)
        kind_q <= req_kind;  // Kind stays valid after the cycle for the strobe decode
    end
  end

  // Address and write data are payload and only follow accepted requests
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  // busy covers T1 through the last T-state
  assign busy = (tstate_q != TS_IDLE);
  assign done = ((tstate_q == TS_T3) && !do_t4) || (tstate_q == TS_T4);

  assign phase.kind    = kind_q;
  assign phase.tstate  = tstate_q;
  assign phase.addr    = addr_q;
  assign phase.wdata   = wdata_q;
  assign phase.waiting = in_wait && stay_wait;
  assign phase.sample  = in_wait && !stay_wait;  // Last T2/Tw, read data is on the bus

endmodule

`default_nettype wire

// File: hw/bus_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module bus_cfg_regs (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                cfg_we,     // One-cycle write strobe
  input  logic [z80_bus_pkg::CFG_ADDR_W-1:0]  cfg_addr,
  input  logic [z80_bus_pkg::DATA_W-1:0]      cfg_wdata,
  output z80_bus_pkg::cfg_t                   cfg         // Current settings
);
  import z80_bus_pkg::*;

  cfg_t cfg_q;  // Control bits and refresh seed in one register

  // Registers are decoded by address, anything else falls through
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      cfg_q <= '0;  // Strobes at T3, no I/O wait, no refresh, seed 0
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        CFG_CTRL:
        begin
          cfg_q.t2_write   <= cfg_wdata[0];
          cfg_q.io_wait    <= cfg_wdata[1];
          cfg_q.refresh_en <= cfg_wdata[2];
        end
        CFG_REFRESH:
        begin
          cfg_q.refresh_seed <= cfg_wdata[REFRESH_W-1:0];  // Top bit of the byte is unused
        end
        default:
        begin
          cfg_q <= cfg_q;  // Unknown address, write is dropped
        end
      endcase
    end
  end

  // Sequencer reads io_wait and refresh_en, strobe generator the rest
  assign cfg = cfg_q;

endmodule

`default_nettype wire

// File: hw/bus_phase_if.sv
`timescale 1ns/10ps
`default_nettype none

// Phase of the current machine cycle as seen by the strobe generator
interface bus_phase_if;
  import z80_bus_pkg::*;

  bus_kind_e         kind;     // Kind of the latched request
  tstate_e           tstate;   // Current T-state
  logic [ADDR_W-1:0] addr;     // Latched request address
  logic [DATA_W-1:0] wdata;    // Latched write data

  // High in T2 or Tw when the next state is another Tw
  logic              waiting;

  // High for the one T2/Tw cycle that leaves the wait phase, read data is valid then
  logic              sample;

  // The sequencer owns the whole phase
  modport seq (
    output kind,
    output tstate,
    output addr,
    output wdata,
    output waiting,
    output sample
  );

  // The strobe generator only follows it
  modport strobe (
    input  kind,
    input  tstate,
    input  addr,
    input  wdata,
    input  waiting,
    input  sample
  );

endinterface

`default_nettype wire

// File: hw/z80_bus_pkg.sv
`default_nettype none

package z80_bus_pkg;

  localparam int ADDR_W     = 16;  // Address bus width
  localparam int DATA_W     = 8;   // Data bus width
  localparam int REFRESH_W  = 7;   // Refresh counter width, as on the Z80 R register
  localparam int CFG_ADDR_W = 2;   // Configuration register address width

  // Configuration register map
  localparam logic [CFG_ADDR_W-1:0] CFG_CTRL    = 2'd0;  // Bit 0 t2_write, bit 1 io_wait, bit 2 refresh_en
  localparam logic [CFG_ADDR_W-1:0] CFG_REFRESH = 2'd1;  // Refresh counter seed

  // Kind of machine cycle requested by the core
  typedef enum logic [2:0] {
    KIND_FETCH     = 3'd0,  // Opcode fetch, M1 cycle
    KIND_MEM_READ  = 3'd1,
    KIND_MEM_WRITE = 3'd2,
    KIND_IO_READ   = 3'd3,
    KIND_IO_WRITE  = 3'd4,
    KIND_INT_ACK   = 3'd5   // Interrupt acknowledge reads the vector from the bus
  } bus_kind_e;

  // T-state of the running machine cycle
  typedef enum logic [2:0] {
    TS_IDLE = 3'd0,
    TS_T1   = 3'd1,
    TS_T2   = 3'd2,
    TS_TW   = 3'd3,  // Wait state, forced or from wait_n
    TS_T3   = 3'd4,
    TS_T4   = 3'd5   // Only reached by fetches with refresh enabled
  } tstate_e;

  // Settings held by the configuration register block
  typedef struct packed {
    logic                 t2_write;      // Write strobe from T2 instead of T3
    logic                 io_wait;       // One automatic wait state on I/O cycles
    logic                 refresh_en;    // Fetches add a refresh T4
    logic [REFRESH_W-1:0] refresh_seed;  // Start value of the refresh counter
  } cfg_t;

  // I/O port cycles, which use iorq_n and may get the automatic wait state
  function automatic logic is_io_kind(input bus_kind_e kind);
    return (kind == KIND_IO_READ) || (kind == KIND_IO_WRITE);
  endfunction

  // Cycles that bring data into the processor
  function automatic logic is_read_kind(input bus_kind_e kind);
    return (kind == KIND_FETCH) || (kind == KIND_MEM_READ) ||
           (kind == KIND_IO_READ) || (kind == KIND_INT_ACK);
  endfunction

endpackage

`default_nettype wire
